//--- src/pmp_consts.svh
// PMP constants
// Entry count and the machine-mode CSR map of the protection registers
// for a 32-bit RISC-V core

`ifndef PMP_CONSTS_SVH
`define PMP_CONSTS_SVH

// Number of protection entries
`define PMP_ENTRIES 16

// pmpcfg0..pmpcfg3, four entries per CSR on RV32
`define PMP_CFG_REGS 4
`define PMP_CFG_BASE 12'h3A0

// pmpaddr0..pmpaddr15
`define PMP_ADDR_BASE 12'h3B0

`endif

//--- src/pmp_pkg.sv
// PMP types
// Address modes, privilege levels and the packed structs passed between
// the CSR file, the checkers and the core side

`default_nettype none

`include "pmp_consts.svh"

package pmp_pkg;

  typedef enum logic [1:0] {
    PMP_OFF   = 2'd0,
    PMP_TOR   = 2'd1,
    PMP_NA4   = 2'd2,
    PMP_NAPOT = 2'd3
  } pmp_mode_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_e;

  // One entry's config byte, same layout as in pmpcfgN
  typedef struct packed {
    logic      l;
    logic [1:0] rsvd;
    pmp_mode_e a;
    logic      x;
    logic      w;
    logic      r;
  } pmp_cfg_t;

  typedef pmp_cfg_t [3:0] pmp_cfg_reg_t; // Byte 0 sits in bits 7:0

  typedef struct packed {
    logic        active;
    logic        write;
    logic [11:0] addr;
    logic [31:0] wdata;
  } csr_req_t;

  typedef struct packed {
    priv_e priv;
    logic  mprv;
    priv_e mpp;
  } priv_ctx_t;

  typedef struct packed {
    logic [31:0] addr;
    logic        r;
    logic        w;
    logic        x;
  } pmp_access_t;

  typedef struct packed {
    logic r;
    logic w;
    logic x;
  } pmp_fault_t;

  typedef pmp_cfg_t [`PMP_ENTRIES-1:0] pmp_entries_t;
  typedef logic [`PMP_ENTRIES-1:0][31:0] pmp_addrs_t;

endpackage

`default_nettype wire

//--- src/pmp_csr_file.sv
// PMP CSR file
// Holds pmpcfg0..3 and pmpaddr0..15. Applies the WARL rules on config
// writes and the lock rules on both config and address writes.
// Reads and the ack decode are combinational on the CSR address.

`default_nettype none

`include "pmp_consts.svh"

module pmp_csr_file (
  input  wire logic                  i_clk,
  input  wire logic                  nRST,
  input  wire pmp_pkg::csr_req_t     i_csr,
  output logic                       o_csr_ack,
  output logic [31:0]                o_csr_rdata,
  output pmp_pkg::pmp_entries_t      o_entries,
  output pmp_pkg::pmp_addrs_t        o_addrs
);

  pmp_pkg::pmp_entries_t   cfg_q;
  pmp_pkg::pmp_addrs_t     addr_q;
  pmp_pkg::pmp_cfg_reg_t   cfg_wr;      // Write data viewed as four cfg bytes
  pmp_pkg::pmp_cfg_reg_t   cfg_rd;

  logic [11:0]             cfg_off;
  logic [11:0]             addr_off;
  logic                    cfg_hit;
  logic                    addr_hit;
  logic [1:0]              cfg_idx;
  logic [3:0]              addr_idx;
  logic                    wr_en;

  logic [`PMP_ENTRIES-1:0] lock_bits;
  logic [`PMP_ENTRIES-1:0] tor_lock_bits;
  logic [`PMP_ENTRIES-1:0] addr_lock;

  // Legalize one cfg byte, a locked byte keeps its old value
  function automatic pmp_pkg::pmp_cfg_t warl_cfg(input pmp_pkg::pmp_cfg_t old_cfg,
                                                 input pmp_pkg::pmp_cfg_t new_cfg);
    pmp_pkg::pmp_cfg_t legal;
    legal      = new_cfg;
    legal.rsvd = 2'b00;
    legal.w    = new_cfg.w & new_cfg.r; // W without R is reserved
    return old_cfg.l ? old_cfg : legal;
  endfunction

  // Address decode, offsets below the base wrap to large values
  assign cfg_off  = i_csr.addr - `PMP_CFG_BASE;
  assign addr_off = i_csr.addr - `PMP_ADDR_BASE;
  assign cfg_hit  = cfg_off < 12'(`PMP_CFG_REGS);
  assign addr_hit = addr_off < 12'(`PMP_ENTRIES);
  assign cfg_idx  = cfg_off[1:0];
  assign addr_idx = addr_off[3:0];
  assign wr_en    = i_csr.active & i_csr.write;
  assign cfg_wr   = pmp_pkg::pmp_cfg_reg_t'(i_csr.wdata);

  always_comb begin
    for (int i = 0; i < `PMP_ENTRIES; i++) begin
      lock_bits[i]     = cfg_q[i].l;
      tor_lock_bits[i] = cfg_q[i].l && (cfg_q[i].a == pmp_pkg::PMP_TOR);
    end
  end

  // pmpaddr i is also frozen when entry i+1 is a locked TOR entry
  assign addr_lock = lock_bits | (tor_lock_bits >> 1);

  always_ff @(posedge i_clk, negedge nRST) begin
    if (!nRST) begin
      cfg_q  <= '0;
      addr_q <= '0;
    end else if (wr_en) begin
      if (cfg_hit) begin
        for (int b = 0; b < 4; b++) begin
          cfg_q[{cfg_idx, 2'(b)}] <= warl_cfg(cfg_q[{cfg_idx, 2'(b)}], cfg_wr[b]);
        end
      end
      if (addr_hit && !addr_lock[addr_idx]) begin
        addr_q[addr_idx] <= i_csr.wdata;
      end
    end
  end

  assign cfg_rd = cfg_q[{cfg_idx, 2'b00} +: 4];

  // Readback, zero outside the map
  always_comb begin
    o_csr_ack   = 1'b0;
    o_csr_rdata = '0;
    if (cfg_hit) begin
      o_csr_ack   = 1'b1;
      o_csr_rdata = cfg_rd;
    end else if (addr_hit) begin
      o_csr_ack   = 1'b1;
      o_csr_rdata = addr_q[addr_idx];
    end
  end

  assign o_entries = cfg_q;
  assign o_addrs   = addr_q;

endmodule

`default_nettype wire

//--- src/pmp_region_match.sv
// PMP region matcher
// Tells whether one word address falls inside one entry's region,
// following the entry's OFF, TOR, NA4 or NAPOT address mode

`default_nettype none

module pmp_region_match (
  input  wire logic [31:0]       i_word_addr, // Byte address shifted right by 2
  input  wire pmp_pkg::pmp_cfg_t i_cfg,
  input  wire logic [31:0]       i_addr_hi,   // pmpaddr of this entry
  input  wire logic [31:0]       i_addr_lo,   // pmpaddr of the entry below, zero for entry 0
  output logic                   o_match
);

  logic [31:0] napot_mask;
  logic        tor_hit;
  logic        na4_hit;
  logic        napot_hit;

  // Trailing ones plus the next zero bit become don't-care bits
  assign napot_mask = ~(i_addr_hi ^ (i_addr_hi + 32'd1));

  assign tor_hit   = (i_word_addr >= i_addr_lo) && (i_word_addr < i_addr_hi);
  assign na4_hit   = i_word_addr == i_addr_hi;
  assign napot_hit = (i_word_addr & napot_mask) == (i_addr_hi & napot_mask);

  always_comb begin
    case (i_cfg.a)
      pmp_pkg::PMP_TOR:   o_match = tor_hit;
      pmp_pkg::PMP_NA4:   o_match = na4_hit;
      pmp_pkg::PMP_NAPOT: o_match = napot_hit;
      default:            o_match = 1'b0; // OFF
    endcase
  end

endmodule

`default_nettype wire

//--- src/pmp_access_check.sv
// PMP access checker
// Matches one access against all entries, takes the lowest-index hit and
// turns its permission bits into per-kind faults. DATA_SIDE selects
// whether mstatus.MPRV may lower the effective privilege.

`default_nettype none

`include "pmp_consts.svh"

module pmp_access_check #(
  parameter bit DATA_SIDE = 1'b1
) (
  input  wire pmp_pkg::pmp_entries_t i_entries,
  input  wire pmp_pkg::pmp_addrs_t   i_addrs,
  input  wire pmp_pkg::priv_ctx_t    i_ctx,
  input  wire pmp_pkg::pmp_access_t  i_access,
  output pmp_pkg::pmp_fault_t        o_fault
);

  logic [31:0]             word_addr;
  logic [`PMP_ENTRIES-1:0] match;
  pmp_pkg::pmp_cfg_t       sel_cfg;
  logic                    hit;
  pmp_pkg::priv_e          eff_priv;
  pmp_pkg::pmp_fault_t     deny;

  assign word_addr = {2'b00, i_access.addr[31:2]};

  for (genvar i = 0; i < `PMP_ENTRIES; i++) begin : g_match
    logic [31:0] addr_lo;

    if (i == 0) begin : g_first
      assign addr_lo = '0; // TOR of entry 0 starts at address zero
    end else begin : g_rest
      assign addr_lo = i_addrs[i-1];
    end

    pmp_region_match u_match (
      .i_word_addr (word_addr),
      .i_cfg       (i_entries[i]),
      .i_addr_hi   (i_addrs[i]),
      .i_addr_lo   (addr_lo),
      .o_match     (match[i])
    );
  end

  // Scan downwards so the lowest matching index is the last one written
  always_comb begin
    hit     = 1'b0;
    sel_cfg = '0;
    for (int i = `PMP_ENTRIES - 1; i >= 0; i--) begin
      if (match[i]) begin
        hit     = 1'b1;
        sel_cfg = i_entries[i];
      end
    end
  end

  // MPRV only lowers the privilege of loads and stores
  assign eff_priv = (DATA_SIDE && i_ctx.mprv) ? i_ctx.mpp : i_ctx.priv;

  always_comb begin
    deny = '0;
    if (!hit) begin
      deny.r = eff_priv != pmp_pkg::PRIV_M; // A miss only denies below M
      deny.w = eff_priv != pmp_pkg::PRIV_M;
      deny.x = eff_priv != pmp_pkg::PRIV_M;
    end else if (eff_priv != pmp_pkg::PRIV_M || sel_cfg.l) begin
      deny.r = !sel_cfg.r;
      deny.w = !sel_cfg.w;
      deny.x = !sel_cfg.x;
    end
  end

  // Only requested kinds can fault
  assign o_fault.r = i_access.r & deny.r;
  assign o_fault.w = i_access.w & deny.w;
  assign o_fault.x = i_access.x & deny.x;

endmodule

`default_nettype wire

//--- src/pmp_unit.sv
// PMP unit top level
// Joins the CSR file with one checker for loads and stores and one for
// instruction fetches, and routes their faults to the core

`default_nettype none

module pmp_unit (
  input  wire logic                 CLK,
  input  wire logic                 nRST,
  input  wire pmp_pkg::csr_req_t    i_csr,
  output logic                      o_csr_ack,
  output logic [31:0]               o_csr_rdata,
  input  wire pmp_pkg::priv_ctx_t   i_ctx,
  input  wire pmp_pkg::pmp_access_t i_data,
  input  wire pmp_pkg::pmp_access_t i_fetch,
  output logic                      o_load_fault,
  output logic                      o_store_fault,
  output logic                      o_fetch_fault
);

  pmp_pkg::pmp_entries_t entries;
  pmp_pkg::pmp_addrs_t   addrs;
  pmp_pkg::pmp_fault_t   data_fault;
  pmp_pkg::pmp_fault_t   fetch_fault;

  pmp_csr_file u_csr (
    .i_clk       (CLK),
    .nRST        (nRST),
    .i_csr       (i_csr),
    .o_csr_ack   (o_csr_ack),
    .o_csr_rdata (o_csr_rdata),
    .o_entries   (entries),
    .o_addrs     (addrs)
  );

  // Loads and stores, MPRV applies
  pmp_access_check #(.DATA_SIDE(1'b1)) data (
    .i_entries (entries),
    .i_addrs   (addrs),
    .i_ctx     (i_ctx),
    .i_access  (i_data),
    .o_fault   (data_fault)
  );

  pmp_access_check #(.DATA_SIDE(1'b0)) fetch (
    .i_entries (entries),
    .i_addrs   (addrs),
    .i_ctx     (i_ctx),
    .i_access  (i_fetch),
    .o_fault   (fetch_fault)
  );

  assign o_load_fault  = data_fault.r;
  assign o_store_fault = data_fault.w;
  assign o_fetch_fault = fetch_fault.x;

endmodule

`default_nettype wire

//--- tests/pmp_unit_asserts.sv
// PMP unit port checker
// Concurrent assertions on the top-level ports of pmp_unit, bound into
// every instance of it

`default_nettype none

`include "pmp_consts.svh"

module pmp_unit_asserts (
  input wire logic                 CLK,
  input wire logic                 nRST,
  input wire pmp_pkg::csr_req_t    i_csr,
  input wire logic                 o_csr_ack,
  input wire logic [31:0]          o_csr_rdata,
  input wire pmp_pkg::pmp_access_t i_data,
  input wire pmp_pkg::pmp_access_t i_fetch,
  input wire logic                 o_load_fault,
  input wire logic                 o_store_fault,
  input wire logic                 o_fetch_fault
);

  logic in_map;
  int   n_fail = 0;

  // pmpcfg0..3 and pmpaddr0..15
  assign in_map = (i_csr.addr >= `PMP_CFG_BASE && i_csr.addr < `PMP_CFG_BASE + 12'd4) ||
                  (i_csr.addr >= `PMP_ADDR_BASE && i_csr.addr < `PMP_ADDR_BASE + 12'd16);

  assert property (@(posedge CLK) disable iff (!nRST) !o_load_fault || i_data.r)
    else begin
      $error("load fault without a load request");
      n_fail++;
    end
  assert property (@(posedge CLK) disable iff (!nRST) !o_store_fault || i_data.w)
    else begin
      $error("store fault without a store request");
      n_fail++;
    end
  assert property (@(posedge CLK) disable iff (!nRST) !o_fetch_fault || i_fetch.x)
    else begin
      $error("fetch fault without a fetch request");
      n_fail++;
    end

  assert property (@(posedge CLK) disable iff (!nRST) o_csr_ack || o_csr_rdata == 32'd0)
    else begin
      $error("read data not zero while ack is low");
      n_fail++;
    end
  assert property (@(posedge CLK) disable iff (!nRST) o_csr_ack == in_map)
    else begin
      $error("ack does not follow the CSR map");
      n_fail++;
    end

endmodule

bind pmp_unit pmp_unit_asserts u_asserts (
  .CLK           (CLK),
  .nRST          (nRST),
  .i_csr         (i_csr),
  .o_csr_ack     (o_csr_ack),
  .o_csr_rdata   (o_csr_rdata),
  .i_data        (i_data),
  .i_fetch       (i_fetch),
  .o_load_fault  (o_load_fault),
  .o_store_fault (o_store_fault),
  .o_fetch_fault (o_fetch_fault)
);

`default_nettype wire

//--- tests/pmp_unit_tb.sv
// PMP unit testbench
// Keeps a shadow of the cfg and addr CSRs, drives CSR traffic and
// accesses on the falling edge, and compares every rising edge against
// a reference model of the matching and permission rules

`default_nettype none

`include "pmp_consts.svh"

module pmp_unit_tb;

  localparam int PERIOD     = 100;
  localparam int N_DIRECTED = 250; // Upper bound on directed steps
  localparam int N_RANDOM   = 300;

  logic                  CLK;
  logic                  nRST;
  pmp_pkg::csr_req_t     csr;
  pmp_pkg::priv_ctx_t    ctx;
  pmp_pkg::pmp_access_t  data_acc;
  pmp_pkg::pmp_access_t  fetch_acc;
  logic                  ack;
  logic [31:0]           rdata;
  logic                  load_f;
  logic                  store_f;
  logic                  fetch_f;

  pmp_pkg::pmp_entries_t sh_cfg;   // Shadow registers
  pmp_pkg::pmp_addrs_t   sh_addr;
  pmp_pkg::pmp_fault_t   exp_d;
  pmp_pkg::pmp_fault_t   exp_f;
  logic [32:0]           exp_csr;  // {ack, rdata}
  int                    n_errors;
  int                    n_checks;
  integer                seed;

  pmp_unit uut (
    .CLK           (CLK),
    .nRST          (nRST),
    .i_csr         (csr),
    .o_csr_ack     (ack),
    .o_csr_rdata   (rdata),
    .i_ctx         (ctx),
    .i_data        (data_acc),
    .i_fetch       (fetch_acc),
    .o_load_fault  (load_f),
    .o_store_fault (store_f),
    .o_fetch_fault (fetch_f)
  );

  always #(PERIOD / 2) CLK = ~CLK;

  // Expected faults from the lowest matching entry and the effective privilege
  function automatic pmp_pkg::pmp_fault_t ref_faults(input pmp_pkg::pmp_entries_t cfgs,
                                                      input pmp_pkg::pmp_addrs_t addrs,
                                                      input pmp_pkg::priv_ctx_t c,
                                                      input pmp_pkg::pmp_access_t acc,
                                                      input bit data_side);
    logic [31:0]         word;
    logic [31:0]         lo;
    int                  k;
    bit                  hit;
    bit                  found;
    pmp_pkg::pmp_cfg_t   sel;
    pmp_pkg::priv_e      pv;
    pmp_pkg::pmp_fault_t f;
    word  = acc.addr >> 2;
    found = 1'b0;
    sel   = '0;
    for (int i = 0; i < `PMP_ENTRIES; i++) begin
      if (i == 0) lo = 32'd0;
      else lo = addrs[i-1];
      k = 0;
      while (k < 32 && addrs[i][k]) k = k + 1; // NAPOT size is 2^(k+3) bytes
      case (cfgs[i].a)
        pmp_pkg::PMP_TOR:   hit = word >= lo && word < addrs[i];
        pmp_pkg::PMP_NA4:   hit = word == addrs[i];
        pmp_pkg::PMP_NAPOT: hit = (word >> (k + 1)) == (addrs[i] >> (k + 1));
        default:            hit = 1'b0;
      endcase
      if (hit && !found) begin
        found = 1'b1;
        sel   = cfgs[i];
      end
    end
    pv = (data_side && c.mprv) ? c.mpp : c.priv;
    f  = '0;
    if (!found) begin
      if (pv != pmp_pkg::PRIV_M) f = '1;
    end else if (pv != pmp_pkg::PRIV_M || sel.l) begin
      f.r = !sel.r;
      f.w = !sel.w;
      f.x = !sel.x;
    end
    f.r = f.r & acc.r;
    f.w = f.w & acc.w;
    f.x = f.x & acc.x;
    return f;
  endfunction

  function automatic logic [32:0] expected_readback(input logic [11:0] a,
                                                    input pmp_pkg::pmp_entries_t cfgs,
                                                    input pmp_pkg::pmp_addrs_t addrs);
    int off;
    logic [32:0] res;
    res = '0;
    if (a >= `PMP_CFG_BASE && a < `PMP_CFG_BASE + 12'd4) begin
      off = int'(a - `PMP_CFG_BASE);
      res = {1'b1, cfgs[off*4+3], cfgs[off*4+2], cfgs[off*4+1], cfgs[off*4]};
    end else if (a >= `PMP_ADDR_BASE && a < `PMP_ADDR_BASE + 12'd16) begin
      off = int'(a - `PMP_ADDR_BASE);
      res = {1'b1, addrs[off]};
    end
    return res;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
    n_errors++;
  endtask

  // Compare on every rising edge after reset
  always @(posedge CLK) begin
    if (nRST) begin
      exp_csr = expected_readback(csr.addr, sh_cfg, sh_addr);
      n_checks++;
      if (ack !== exp_csr[32]) report_mismatch("o_csr_ack", 32'(exp_csr[32]), 32'(ack));
      // The shadow runs one edge ahead of the DUT during a write
      if (!(csr.active && csr.write)) begin
        exp_d = ref_faults(sh_cfg, sh_addr, ctx, data_acc, 1'b1);
        exp_f = ref_faults(sh_cfg, sh_addr, ctx, fetch_acc, 1'b0);
        if (rdata !== exp_csr[31:0]) report_mismatch("o_csr_rdata", exp_csr[31:0], rdata);
        if (load_f !== exp_d.r) report_mismatch("o_load_fault", 32'(exp_d.r), 32'(load_f));
        if (store_f !== exp_d.w) report_mismatch("o_store_fault", 32'(exp_d.w), 32'(store_f));
        if (fetch_f !== exp_f.x) report_mismatch("o_fetch_fault", 32'(exp_f.x), 32'(fetch_f));
      end
    end
  end

  // Drive one write and apply the WARL and lock rules to the shadow
  task automatic write_csr(input logic [11:0] a, input logic [31:0] d);
    int off;
    logic [7:0] b;
    @(negedge CLK);
    csr = '{active: 1'b1, write: 1'b1, addr: a, wdata: d};
    if (a >= `PMP_CFG_BASE && a < `PMP_CFG_BASE + 12'd4) begin
      off = int'(a - `PMP_CFG_BASE);
      for (int i = 0; i < 4; i++) begin
        b      = d[8*i +: 8];
        b[6:5] = 2'b00;
        if (!b[0]) b[1] = 1'b0; // W needs R
        if (!sh_cfg[off*4+i].l) sh_cfg[off*4+i] = pmp_pkg::pmp_cfg_t'(b);
      end
    end else if (a >= `PMP_ADDR_BASE && a < `PMP_ADDR_BASE + 12'd16) begin
      off = int'(a - `PMP_ADDR_BASE);
      if (!sh_cfg[off].l && !(off < `PMP_ENTRIES - 1 && sh_cfg[off+1].l &&
                              sh_cfg[off+1].a == pmp_pkg::PMP_TOR))
        sh_addr[off] = d;
    end
  endtask

  task automatic read_csr(input logic [11:0] a);
    @(negedge CLK);
    csr = '{active: 1'b1, write: 1'b0, addr: a, wdata: 32'h0};
  endtask

  task automatic read_all();
    for (int i = 0; i < 4; i++) read_csr(`PMP_CFG_BASE + 12'(i));
    for (int i = 0; i < `PMP_ENTRIES; i++) read_csr(`PMP_ADDR_BASE + 12'(i));
  endtask

  // req is {load, store, fetch} and both sides use the same address
  task automatic drive_access(input pmp_pkg::priv_e pv, input logic use_mprv,
                              input pmp_pkg::priv_e mpp, input logic [31:0] a,
                              input logic [2:0] req);
    @(negedge CLK);
    csr.active = 1'b0; // The last CSR address stays on the bus with the strobe low
    csr.write  = 1'b0;
    ctx        = '{priv: pv, mprv: use_mprv, mpp: mpp};
    data_acc   = '{addr: a, r: req[2], w: req[1], x: 1'b0};
    fetch_acc  = '{addr: a, r: 1'b0, w: 1'b0, x: req[0]};
  endtask

  initial begin : watchdog
    #((N_DIRECTED + N_RANDOM) * 4 * PERIOD + 200 * PERIOD);
    $display("Timeout: the stimulus did not complete in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : stimulus
    logic [31:0]    r;
    logic [31:0]    a;
    logic [31:0]    edges [17];
    pmp_pkg::priv_e pv;
    CLK       = 1'b0;
    nRST      = 1'b0;
    csr       = '0;
    ctx       = '{priv: pmp_pkg::PRIV_M, mprv: 1'b0, mpp: pmp_pkg::PRIV_U};
    data_acc  = '0;
    fetch_acc = '0;
    sh_cfg    = '0;
    sh_addr   = '0;
    n_errors  = 0;
    n_checks  = 0;
    seed      = 32'h86ac_26af;
    repeat (4) @(negedge CLK);
    nRST = 1'b1;

    // Reset state
    read_all();
    drive_access(pmp_pkg::PRIV_M, 1'b0, pmp_pkg::PRIV_U, 32'h0000_1000, 3'b111);
    drive_access(pmp_pkg::PRIV_U, 1'b0, pmp_pkg::PRIV_U, 32'h0000_1000, 3'b111);

    // WARL on reserved bits and on W without R followed by writes outside the map
    write_csr(`PMP_CFG_BASE, 32'h6E62_7B02);
    read_all();
    write_csr(12'h39F, 32'hFFFF_FFFF);
    write_csr(12'h3A4, 32'hFFFF_FFFF);
    write_csr(12'h3AF, 32'hFFFF_FFFF);
    write_csr(12'h3C0, 32'hFFFF_FFFF);
    read_csr(12'h39F);
    read_csr(12'h3A4);
    read_csr(12'h3AF);
    read_csr(12'h3C0);
    read_all();
    write_csr(`PMP_CFG_BASE, 32'h0);

    // NA4 at 0x1000, NAPOT 4K at 0x1000, TOR up to 0x2000, NAPOT 8B at 0x3000,
    // TOR up to 0x4000, NAPOT 2G at 0x8000_0000
    write_csr(`PMP_ADDR_BASE + 12'd0, 32'h0000_0400);
    write_csr(`PMP_ADDR_BASE + 12'd1, 32'h0000_05FF);
    write_csr(`PMP_ADDR_BASE + 12'd2, 32'h0000_0800);
    write_csr(`PMP_ADDR_BASE + 12'd3, 32'h0000_0C00);
    write_csr(`PMP_ADDR_BASE + 12'd4, 32'h0000_1000);
    write_csr(`PMP_ADDR_BASE + 12'd5, 32'h2FFF_FFFF);
    write_csr(`PMP_CFG_BASE, 32'h1C0B_1F11);
    write_csr(`PMP_CFG_BASE + 12'd1, 32'h0000_190D);
    read_all();
    edges = '{32'h0000_0FFC, 32'h0000_1000, 32'h0000_1004, 32'h0000_17F8, 32'h0000_17FC,
              32'h0000_1FFC, 32'h0000_1FFF, 32'h0000_2000, 32'h0000_2FFC, 32'h0000_3000,
              32'h0000_3007, 32'h0000_3008, 32'h0000_3FFC, 32'h0000_4000, 32'h7FFF_FFFC,
              32'h8000_0000, 32'hFFFF_FFFF};
    foreach (edges[j]) begin
      drive_access(pmp_pkg::PRIV_U, 1'b0, pmp_pkg::PRIV_U, edges[j], 3'b111);
      drive_access(pmp_pkg::PRIV_S, 1'b0, pmp_pkg::PRIV_U, edges[j], 3'b111);
      drive_access(pmp_pkg::PRIV_M, 1'b0, pmp_pkg::PRIV_U, edges[j], 3'b111);
    end

    // MPRV lowers the data side only
    drive_access(pmp_pkg::PRIV_M, 1'b1, pmp_pkg::PRIV_U, 32'h0000_3000, 3'b111);
    drive_access(pmp_pkg::PRIV_M, 1'b1, pmp_pkg::PRIV_U, 32'h0000_5000, 3'b111);
    drive_access(pmp_pkg::PRIV_M, 1'b0, pmp_pkg::PRIV_U, 32'h0000_5000, 3'b111);
    drive_access(pmp_pkg::PRIV_M, 1'b1, pmp_pkg::PRIV_S, 32'h0000_1000, 3'b111);
    drive_access(pmp_pkg::PRIV_U, 1'b1, pmp_pkg::PRIV_M, 32'h0000_5000, 3'b111);

    // Entry 9 becomes a locked TOR entry and entry 10 a locked NA4 entry
    write_csr(`PMP_ADDR_BASE + 12'd8, 32'h0000_2400);
    write_csr(`PMP_ADDR_BASE + 12'd9, 32'h0000_2800);
    write_csr(`PMP_ADDR_BASE + 12'd10, 32'h0000_2C00);
    write_csr(`PMP_ADDR_BASE + 12'd11, 32'h0000_3000);
    write_csr(`PMP_CFG_BASE + 12'd2, 32'h0091_8917);
    write_csr(`PMP_CFG_BASE + 12'd2, 32'h0F00_000F);
    for (int i = 7; i < 12; i++) write_csr(`PMP_ADDR_BASE + 12'(i), 32'h0000_7777 + i);
    read_all();
    drive_access(pmp_pkg::PRIV_M, 1'b0, pmp_pkg::PRIV_U, 32'h0000_9004, 3'b111);
    drive_access(pmp_pkg::PRIV_M, 1'b0, pmp_pkg::PRIV_U, 32'h0000_9FFC, 3'b111);
    drive_access(pmp_pkg::PRIV_M, 1'b0, pmp_pkg::PRIV_U, 32'h0000_B000, 3'b111);
    drive_access(pmp_pkg::PRIV_U, 1'b0, pmp_pkg::PRIV_U, 32'h0000_B000, 3'b111);

    // Random accesses with about half of them near the configured regions
    for (int n = 0; n < N_RANDOM; n++) begin
      r = $random(seed);
      a = $random(seed);
      if (r[2]) a = a & 32'h0000_FFFF;
      pv = (r[1:0] == 2'd2) ? pmp_pkg::PRIV_M : pmp_pkg::priv_e'(r[1:0]);
      drive_access(pv, r[4], r[5] ? pmp_pkg::PRIV_M : pmp_pkg::PRIV_U, a, r[8:6]);
    end
    read_all();
    @(negedge CLK);

    $display("Checks: %0d, errors: %0d, assertion failures: %0d", n_checks, n_errors,
             uut.u_asserts.n_fail);
    if (n_errors == 0 && uut.u_asserts.n_fail == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+src
src/pmp_pkg.sv
src/pmp_csr_file.sv
src/pmp_region_match.sv
src/pmp_access_check.sv
src/pmp_unit.sv
tests/pmp_unit_asserts.sv
tests/pmp_unit_tb.sv

//--- Makefile
# Verilator flow for the PMP unit testbench
# Override on the command line, e.g. make sim SEED=5

VERILATOR ?= verilator
TOP       ?= pmp_unit_tb
SEED      ?= 1
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Pass only if the pass line shows up in the simulator output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
